/* logic/readout_cfg.svh */
////////////////////
// Hit readout configuration
// FIFO depths, timestamp width and register map
////////////////////

`ifndef READOUT_CFG_SVH
`define READOUT_CFG_SVH

// Buffer depths, usable capacity is one less
`define RO_HIT_DEPTH 16
`define RO_OUT_DEPTH 8

// Free-running hit timestamp
`define RO_TS_WIDTH 16

// Register map
`define RO_REG_AW 2
`define RO_ADDR_CTRL 0
`define RO_ADDR_STATUS 1
`define RO_ADDR_LOST 2

`endif

/* logic/readout_pkg.sv */
////////////////////
// Hit readout types
// Hit, stored hit, readout word, control and status
////////////////////

`include "readout_cfg.svh"

package readout_pkg;

    // Front-end hit as delivered with the strobe
    typedef struct packed {
        logic [5:0] column;
        logic [8:0] row;
        logic [3:0] tot;
    } hit_in_t;

    // Hit with its arrival timestamp
    typedef struct packed {
        hit_in_t                  hit;
        logic [`RO_TS_WIDTH-1:0]  ts;
    } hit_word_t;

    // Readout word, header words use only tag and ts_byte
    typedef struct packed {
        logic       tag;
        logic [5:0] column;
        logic [8:0] row;
        logic [3:0] tot;
        logic [3:0] spare;
        logic [7:0] ts_byte;
    } ro_word_t;

    localparam logic TAG_DATA = 1'b0;
    localparam logic TAG_HEADER = 1'b1;

    typedef struct packed {
        logic enable;
        logic clear_lost;
    } ro_ctrl_t;

    typedef struct packed {
        logic [$clog2(`RO_HIT_DEPTH)-1:0] hit_size;
        logic [$clog2(`RO_OUT_DEPTH)-1:0] out_size;
        logic [15:0]                      lost;
    } ro_status_t;

endpackage

/* logic/generic_fifo.sv */
////////////////////
// Generic FIFO
// Circular buffer with registered lookahead output,
// capacity of DEPTH-1 words and combinational fill level
////////////////////

`timescale 1ns/10ps

module generic_fifo #(
    parameter type T = logic [31:0],
    parameter int DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       write,
    input  logic                       read,
    input  T                           data_in,
    output logic                       full,
    output logic                       empty,
    output T                           data_out,
    output logic [$clog2(DEPTH)-1:0]   size
);

    localparam int PW = $clog2(DEPTH);

    T mem [DEPTH];

    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_look;
    logic          rd_en;
    logic          wr_en;

    // Pointer advance with wrap at DEPTH
    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
        if (p == PW'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign rd_en = read && !empty;
    assign wr_en = write && !full;

    // Full one slot short of wrap
    assign full = (ptr_inc(wr_ptr) == rd_ptr);

    // Address of the word to present after this edge
    always_comb begin
        rd_look = rd_ptr;
        if (rd_en) begin
            rd_look = ptr_inc(rd_ptr);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= ptr_inc(rd_ptr);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= ptr_inc(wr_ptr);
        end
    end

    // Empty looks ahead when a read drains the last word
    always_ff @(posedge clk) begin
        if (reset) begin
            empty <= 1'b1;
        end else if (rd_en) begin
            empty <= (wr_ptr == rd_look);
        end else begin
            empty <= (wr_ptr == rd_ptr);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // Head word always presented
    always_ff @(posedge clk) begin
        data_out <= mem[rd_look];
    end

    always_comb begin
        if (wr_ptr >= rd_ptr) begin
            size = wr_ptr - rd_ptr;
        end else begin
            size = PW'(DEPTH - int'(rd_ptr) + int'(wr_ptr));
        end
    end

endmodule

/* logic/hit_framer.sv */
////////////////////
// Hit framer
// Stamps incoming hits with a free-running timestamp,
// writes them to the hit FIFO and counts lost hits
////////////////////

`timescale 1ns/10ps

`include "readout_cfg.svh"

module hit_framer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   hit,
    input  readout_pkg::hit_in_t   hit_data,
    input  readout_pkg::ro_ctrl_t  ctrl,
    input  logic                   fifo_full,
    output logic                   fifo_write,
    output readout_pkg::hit_word_t fifo_data,
    output logic [15:0]            lost_count
);

    logic [`RO_TS_WIDTH-1:0] ts;
    logic                    hit_lost;

    // Zero in the first cycle after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            ts <= '0;
        end else begin
            ts <= ts + 1'b1;
        end
    end

    // Accepted in the cycle it arrives
    assign fifo_write = hit && ctrl.enable && !fifo_full;
    assign hit_lost = hit && ctrl.enable && fifo_full;

    always_comb begin
        fifo_data.hit = hit_data;
        fifo_data.ts = ts;
    end

    // Saturating loss counter, clear wins
    always_ff @(posedge clk) begin
        if (reset) begin
            lost_count <= '0;
        end else if (ctrl.clear_lost) begin
            lost_count <= '0;
        end else if (hit_lost && (lost_count != '1)) begin
            lost_count <= lost_count + 1'b1;
        end
    end

endmodule

/* logic/readout_regs.sv */
////////////////////
// Readout registers
// Enable and lost-count clear, status and lost readback
////////////////////

`timescale 1ns/10ps

`include "readout_cfg.svh"

module readout_regs (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      reg_wr,
    input  logic [`RO_REG_AW-1:0]     reg_addr,
    input  logic [15:0]               reg_wdata,
    output logic [15:0]               reg_rdata,
    output readout_pkg::ro_ctrl_t     ctrl,
    input  readout_pkg::ro_status_t   status
);

    localparam logic [`RO_REG_AW-1:0] ADDR_CTRL = `RO_REG_AW'(`RO_ADDR_CTRL);
    localparam logic [`RO_REG_AW-1:0] ADDR_STATUS = `RO_REG_AW'(`RO_ADDR_STATUS);
    localparam logic [`RO_REG_AW-1:0] ADDR_LOST = `RO_REG_AW'(`RO_ADDR_LOST);

    logic ctrl_wr;

    assign ctrl_wr = reg_wr && (reg_addr == ADDR_CTRL);

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl.enable <= 1'b0;
        end else if (ctrl_wr) begin
            ctrl.enable <= reg_wdata[0];
        end
    end

    // Clear command, one cycle wide
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl.clear_lost <= 1'b0;
        end else begin
            ctrl.clear_lost <= ctrl_wr && reg_wdata[1];
        end
    end

    // Readback one cycle after the address
    always_ff @(posedge clk) begin
        case (reg_addr)
            ADDR_CTRL: begin
                reg_rdata <= {15'd0, ctrl.enable};
            end
            ADDR_STATUS: begin
                reg_rdata <= 16'({status.out_size, status.hit_size});
            end
            ADDR_LOST: begin
                reg_rdata <= status.lost;
            end
            default: begin
                reg_rdata <= '0;
            end
        endcase
    end

endmodule

/* logic/word_encoder.sv */
////////////////////
// Word encoder
// Turns stored hits into readout words, with a header
// ahead of each change of the timestamp high byte
////////////////////

`timescale 1ns/10ps

`include "readout_cfg.svh"

module word_encoder (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   hit_empty,
    input  readout_pkg::hit_word_t hit_word,
    output logic                   hit_read,
    input  logic                   out_full,
    output logic                   out_write,
    output readout_pkg::ro_word_t  out_word
);

    import readout_pkg::*;

    logic [7:0] last_hi;
    logic       hdr_sent;
    logic [7:0] ts_hi;
    logic [7:0] ts_lo;
    logic       header_due;

    assign ts_hi = hit_word.ts[`RO_TS_WIDTH-1 -: 8];
    assign ts_lo = hit_word.ts[7:0];

    assign header_due = !hdr_sent || (ts_hi != last_hi);

    // One word per cycle while a hit waits and space is left
    assign out_write = !hit_empty && !out_full;
    // Hit consumed only with its data word
    assign hit_read = out_write && !header_due;

    always_comb begin
        out_word = '0;
        if (header_due) begin
            out_word.tag = TAG_HEADER;
            out_word.ts_byte = ts_hi;
        end else begin
            out_word.tag = TAG_DATA;
            out_word.column = hit_word.hit.column;
            out_word.row = hit_word.hit.row;
            out_word.tot = hit_word.hit.tot;
            out_word.ts_byte = ts_lo;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hdr_sent <= 1'b0;
            last_hi <= '0;
        end else if (out_write && header_due) begin
            hdr_sent <= 1'b1;
            last_hi <= ts_hi;
        end
    end

endmodule

/* logic/hit_readout_top.sv */
////////////////////
// Hit readout buffer
// Framer, hit FIFO, word encoder, output FIFO and
// register block
////////////////////

`timescale 1ns/10ps

`include "readout_cfg.svh"

module hit_readout_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  hit,
    input  readout_pkg::hit_in_t  hit_data,
    input  logic                  reg_wr,
    input  logic [`RO_REG_AW-1:0] reg_addr,
    input  logic [15:0]           reg_wdata,
    output logic [15:0]           reg_rdata,
    input  logic                  out_read,
    output readout_pkg::ro_word_t out_data,
    output logic                  out_empty
);

    import readout_pkg::*;

    ro_ctrl_t   ctrl;
    ro_status_t status;
    logic [15:0] lost_count;

    // Hit FIFO side
    logic       hit_fifo_write;
    hit_word_t  hit_fifo_in;
    logic       hit_fifo_full;
    logic       hit_fifo_empty;
    logic       hit_fifo_read;
    hit_word_t  hit_fifo_out;
    logic [$clog2(`RO_HIT_DEPTH)-1:0] hit_fifo_size;

    // Output FIFO side
    logic       out_fifo_write;
    ro_word_t   out_fifo_in;
    logic       out_fifo_full;
    logic [$clog2(`RO_OUT_DEPTH)-1:0] out_fifo_size;

    assign status = '{hit_size: hit_fifo_size, out_size: out_fifo_size, lost: lost_count};

    hit_framer framer (
        .clk(clk), .reset(reset), .hit(hit), .hit_data(hit_data), .ctrl(ctrl),
        .fifo_full(hit_fifo_full), .fifo_write(hit_fifo_write),
        .fifo_data(hit_fifo_in), .lost_count(lost_count)
    );

    readout_regs regs (
        .clk(clk), .reset(reset), .reg_wr(reg_wr), .reg_addr(reg_addr),
        .reg_wdata(reg_wdata), .reg_rdata(reg_rdata), .ctrl(ctrl), .status(status)
    );

    generic_fifo #(.T(hit_word_t), .DEPTH(`RO_HIT_DEPTH)) hit_fifo (
        .clk(clk), .reset(reset), .write(hit_fifo_write), .read(hit_fifo_read),
        .data_in(hit_fifo_in), .full(hit_fifo_full), .empty(hit_fifo_empty),
        .data_out(hit_fifo_out), .size(hit_fifo_size)
    );

    word_encoder encoder (
        .clk(clk), .reset(reset), .hit_empty(hit_fifo_empty), .hit_word(hit_fifo_out),
        .hit_read(hit_fifo_read), .out_full(out_fifo_full),
        .out_write(out_fifo_write), .out_word(out_fifo_in)
    );

    generic_fifo #(.T(ro_word_t), .DEPTH(`RO_OUT_DEPTH)) out_fifo (
        .clk(clk), .reset(reset), .write(out_fifo_write), .read(out_read),
        .data_in(out_fifo_in), .full(out_fifo_full), .empty(out_empty),
        .data_out(out_data), .size(out_fifo_size)
    );

endmodule

/* bench/hit_readout_props.sv */
////////////////////
// Readout buffer properties
// Output holding, encoder back-pressure,
// lost count and state after reset
////////////////////

`timescale 1ns/10ps

`include "readout_cfg.svh"

module hit_readout_props (
    input logic                               clk,
    input logic                               reset,
    input logic                               out_read,
    input readout_pkg::ro_word_t              out_data,
    input logic                               out_empty,
    input logic                               enc_write,
    input logic [$clog2(`RO_OUT_DEPTH)-1:0]   out_size,
    input logic [15:0]                        lost_count,
    input readout_pkg::ro_ctrl_t              ctrl
);

    // Head word stays until it is read
    hold_head: assert property (@(posedge clk) disable iff (reset)
        !out_read && !out_empty |=> $stable(out_data))
        else $error("out_data changed while no read was issued");

    // Every encoder word is taken by the output FIFO
    write_taken: assert property (@(posedge clk) disable iff (reset)
        enc_write && !(out_read && !out_empty) |=> out_size == $past(out_size) + 1'b1)
        else $error("encoder word was not stored in the output FIFO");

    lost_never_drops: assert property (@(posedge clk) disable iff (reset)
        !ctrl.clear_lost |=> lost_count >= $past(lost_count))
        else $error("lost count decreased without a clear");

    empty_after_reset: assert property (@(posedge clk)
        $past(reset) |-> out_empty)
        else $error("output FIFO not empty right after reset");

endmodule

bind hit_readout_top hit_readout_props props (
    .clk(clk), .reset(reset), .out_read(out_read), .out_data(out_data),
    .out_empty(out_empty), .enc_write(out_fifo_write), .out_size(out_fifo_size),
    .lost_count(lost_count), .ctrl(ctrl)
);

/* bench/hit_readout_tb.sv */
////////////////////
// Hit readout testbench
// Random hits and reads against a cycle model of both FIFOs
////////////////////

`timescale 1ns/10ps

`include "readout_cfg.svh"

module hit_readout_tb;

    import readout_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 10;
    localparam int GATED_CYCLES = 50;
    localparam int PHASE_CYCLES = 200;
    localparam int NUM_PHASES = 6;
    localparam int IDLE_GAP = 300;
    localparam int BURST_CYCLES = 40;
    localparam int SETTLE_LIMIT = 200;
    localparam int STIM_CYCLES = RESET_CYCLES + GATED_CYCLES + NUM_PHASES * PHASE_CYCLES
                                 + IDLE_GAP + BURST_CYCLES;
    localparam int WATCHDOG_CYCLES = STIM_CYCLES + 8 * SETTLE_LIMIT + 100;

    localparam logic [`RO_REG_AW-1:0] ADDR_CTRL = `RO_REG_AW'(`RO_ADDR_CTRL);
    localparam logic [`RO_REG_AW-1:0] ADDR_STATUS = `RO_REG_AW'(`RO_ADDR_STATUS);
    localparam logic [`RO_REG_AW-1:0] ADDR_LOST = `RO_REG_AW'(`RO_ADDR_LOST);

    logic                  clk;
    logic                  reset;
    logic                  hit;
    hit_in_t               hit_data;
    logic                  reg_wr;
    logic [`RO_REG_AW-1:0] reg_addr;
    logic [15:0]           reg_wdata;
    logic [15:0]           reg_rdata;
    logic                  out_read;
    ro_word_t              out_data;
    logic                  out_empty;

    // Model state
    hit_word_t   hq[$];
    logic [31:0] oq[$];
    logic        h_empty_m = 1'b1;
    logic        o_empty_m = 1'b1;
    logic        hdr_sent_m = 1'b0;
    logic [7:0]  last_hi_m = '0;
    logic        enable_m = 1'b0;
    logic        clear_m = 1'b0;
    logic [15:0] lost_m = '0;
    logic [`RO_TS_WIDTH-1:0] ts_m = '0;
    int          accepted_m = 0;
    int          data_read = 0;

    logic [31:0] rng_state = 32'hb2c77a2d;
    int          check_count = 0;
    int          mismatch_count = 0;
    int          other_errors = 0;

    hit_readout_top uut (
        .clk(clk), .reset(reset), .hit(hit), .hit_data(hit_data),
        .reg_wr(reg_wr), .reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
        .out_read(out_read), .out_data(out_data), .out_empty(out_empty)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        logic [31:0] s;
        s = rng_state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rng_state = s;
        return s;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            mismatch_count++;
            $display("MISMATCH %s: got %h, expected %h at %0t", name, got, expected, $time);
        end
    endtask

    // One clock edge of the readout chain, on pre-edge inputs
    task automatic model_step();
        logic        h_full;
        logic        o_full;
        logic        fr_write;
        logic        lost_inc;
        logic        enc_write;
        logic        enc_read;
        logic        hdr_due;
        logic        o_read;
        logic        ctrl_wr;
        logic [7:0]  head_hi;
        logic [31:0] word;
        hit_word_t   stored;
        int          h_cnt;
        int          o_cnt;
        if (reset) begin
            hq.delete();
            oq.delete();
            h_empty_m = 1'b1;
            o_empty_m = 1'b1;
            hdr_sent_m = 1'b0;
            last_hi_m = '0;
            enable_m = 1'b0;
            clear_m = 1'b0;
            lost_m = '0;
            ts_m = '0;
        end else begin
            h_cnt = hq.size();
            o_cnt = oq.size();
            h_full = (h_cnt == `RO_HIT_DEPTH - 1);
            o_full = (o_cnt == `RO_OUT_DEPTH - 1);
            fr_write = hit && enable_m && !h_full;
            lost_inc = hit && enable_m && h_full;
            enc_write = !h_empty_m && !o_full && (h_cnt > 0);
            hdr_due = 1'b0;
            head_hi = '0;
            word = '0;
            if (enc_write) begin
                head_hi = hq[0].ts[`RO_TS_WIDTH-1 -: 8];
                hdr_due = !hdr_sent_m || (head_hi != last_hi_m);
                if (hdr_due) begin
                    word = {1'b1, 23'd0, head_hi};
                end else begin
                    word = {1'b0, hq[0].hit.column, hq[0].hit.row, hq[0].hit.tot,
                            4'd0, hq[0].ts[7:0]};
                end
            end
            enc_read = enc_write && !hdr_due;
            o_read = out_read && !o_empty_m;
            ctrl_wr = reg_wr && (reg_addr == ADDR_CTRL);
            // Empty flags lag a write by one edge, but see a draining read at once
            h_empty_m = (h_cnt - int'(enc_read)) == 0;
            o_empty_m = (o_cnt - int'(o_read)) == 0;
            if (o_read) begin
                void'(oq.pop_front());
            end
            if (enc_read) begin
                void'(hq.pop_front());
            end
            if (enc_write) begin
                oq.push_back(word);
                if (hdr_due) begin
                    hdr_sent_m = 1'b1;
                    last_hi_m = head_hi;
                end
            end
            if (fr_write) begin
                stored.hit = hit_data;
                stored.ts = ts_m;
                hq.push_back(stored);
                accepted_m++;
            end
            if (clear_m) begin
                lost_m = '0;
            end else if (lost_inc && (lost_m != 16'hffff)) begin
                lost_m = lost_m + 1'b1;
            end
            clear_m = ctrl_wr && reg_wdata[1];
            if (ctrl_wr) begin
                enable_m = reg_wdata[0];
            end
            ts_m = ts_m + 1'b1;
        end
    endtask

    always @(posedge clk) begin
        model_step();
    end

    // Output side compared mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            check_value("out_empty", 32'(out_empty), 32'(o_empty_m));
            if (out_read && !o_empty_m && (oq.size() > 0)) begin
                check_value("out_data", out_data, oq[0]);
            end
            if (out_read && !out_empty && (out_data.tag == TAG_DATA)) begin
                data_read++;
            end
        end
    end

    function automatic logic chain_at_rest();
        logic flags_ok;
        flags_ok = (h_empty_m == (hq.size() == 0)) && (o_empty_m == (oq.size() == 0));
        return flags_ok && ((hq.size() == 0) || (oq.size() == `RO_OUT_DEPTH - 1))
               && (!out_read || (oq.size() == 0));
    endfunction

    task automatic run_hits(input int cycles, input int hit_pct, input int read_pct);
        logic [31:0] r;
        int          i;
        for (i = 0; i < cycles; i++) begin
            @(posedge clk);
            r = next_random();
            hit <= (r % 100) < hit_pct;
            r = next_random();
            hit_data <= r[18:0];
            r = next_random();
            out_read <= (r % 100) < read_pct;
        end
        @(posedge clk);
        hit <= 1'b0;
    endtask

    // Hits off, then wait for both FIFOs to come to rest
    task automatic settle(input logic read_level);
        int waited;
        waited = 0;
        @(posedge clk);
        hit <= 1'b0;
        out_read <= read_level;
        @(negedge clk);
        while (!chain_at_rest() && (waited < SETTLE_LIMIT)) begin
            @(negedge clk);
            waited++;
        end
        if (!chain_at_rest()) begin
            other_errors++;
            $display("ERROR: readout did not settle within %0d cycles at %0t",
                     SETTLE_LIMIT, $time);
        end
    endtask

    task automatic write_reg(input logic [`RO_REG_AW-1:0] addr, input logic [15:0] data);
        @(posedge clk);
        reg_wr <= 1'b1;
        reg_addr <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_wr <= 1'b0;
    endtask

    task automatic read_reg(input logic [`RO_REG_AW-1:0] addr, output logic [15:0] data);
        @(posedge clk);
        reg_addr <= addr;
        @(posedge clk);
        @(negedge clk);
        data = reg_rdata;
    endtask

    task automatic verify_status();
        logic [15:0] rd;
        read_reg(ADDR_STATUS, rd);
        check_value("status", 32'(rd), 32'((oq.size() << 4) | hq.size()));
    endtask

    initial begin
        logic [15:0] rd;
        int          p;
        reset = 1'b1;
        hit = 1'b0;
        hit_data = '0;
        reg_wr = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        out_read = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // Hits go nowhere while enable is clear
        run_hits(GATED_CYCLES, 50, 100);
        settle(1'b1);
        read_reg(ADDR_CTRL, rd);
        check_value("ctrl", 32'(rd), 32'(enable_m));
        read_reg(ADDR_LOST, rd);
        check_value("lost_count", 32'(rd), 32'(lost_m));

        write_reg(ADDR_CTRL, 16'h0001);
        read_reg(ADDR_CTRL, rd);
        check_value("ctrl", 32'(rd), 32'(enable_m));

        // Sparse with eager reads, then bursts with slow reads
        for (p = 0; p < NUM_PHASES; p++) begin
            if (p % 2 == 0) begin
                run_hits(PHASE_CYCLES, 10, 90);
            end else begin
                run_hits(PHASE_CYCLES, 70, 15);
            end
            if (p == 2) begin
                run_hits(IDLE_GAP, 0, 100);
            end
        end
        settle(1'b1);
        verify_status();

        // Reader stalled through a burst
        run_hits(BURST_CYCLES, 80, 0);
        settle(1'b0);
        verify_status();
        read_reg(ADDR_LOST, rd);
        check_value("lost_count", 32'(rd), 32'(lost_m));
        write_reg(ADDR_CTRL, 16'h0003);
        read_reg(ADDR_LOST, rd);
        check_value("lost_count", 32'(rd), 32'(lost_m));

        settle(1'b1);
        verify_status();
        check_value("data_words", 32'(data_read), 32'(accepted_m));

        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 check_count, mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, stimulus never completed",
                 WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+logic
logic/readout_pkg.sv
logic/generic_fifo.sv
logic/hit_framer.sv
logic/readout_regs.sv
logic/word_encoder.sv
logic/hit_readout_top.sv
bench/hit_readout_props.sv
bench/hit_readout_tb.sv
